// File: common/ex_pkg.sv
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Shared types for the execute stage and register file
//////////////////////////////////////////////////////////////////////

package ex_pkg;

  // Data path width
  localparam int WORD_W = 32;

  // Register index width and register count
  localparam int ADDR_W    = 5;
  localparam int REG_COUNT = 32;

  // One data word, used for operands, results and register contents
  typedef logic [WORD_W-1:0] word_t;

  // Register file index
  typedef logic [ADDR_W-1:0] reg_addr_t;

  // ALU operation code
  // Compare group sits at the end of the encoding
  typedef enum logic [4:0] {
    ALU_ADD  = 5'd0,
    ALU_SUB  = 5'd1,
    ALU_AND  = 5'd2,
    ALU_OR   = 5'd3,
    ALU_XOR  = 5'd4,
    ALU_SLL  = 5'd5,
    ALU_SRL  = 5'd6,
    ALU_SRA  = 5'd7,
    ALU_SLTS = 5'd8,
    ALU_SLTU = 5'd9,
    ALU_EQ   = 5'd10,
    ALU_NE   = 5'd11,
    ALU_LTS  = 5'd12,
    ALU_LTU  = 5'd13,
    ALU_GES  = 5'd14,
    ALU_GEU  = 5'd15
  } alu_op_e;

  // ALU request from decode
  // Operand c doubles as jump target and MAC addend
  typedef struct packed {
    alu_op_e operator;
    word_t   a;
    word_t   b;
    word_t   c;
  } alu_req_t;

  // Multiplier controls
  typedef struct packed {
    // Pick the multiplier result over the ALU
    logic       en;
    // Halfword operands instead of full words
    logic       vector_mode;
    // Bit 0 upper half of a, bit 1 upper half of b
    logic [1:0] sel_subword;
    // Bit 0 a is signed, bit 1 b is signed
    logic [1:0] signed_mode;
    // Add operand c to the product
    logic       mac_en;
  } mult_req_t;

  // Write port into the register file, also the forwarding path
  typedef struct packed {
    logic      we;
    reg_addr_t waddr;
    word_t     wdata;
  } rf_wr_t;

endpackage

`default_nettype wire

// File: ex_stage/ex_alu.sv
`timescale 1ns/100ps
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Integer ALU
//////////////////////////////////////////////////////////////////////

module ex_alu
  import ex_pkg::*;
(
  input  alu_req_t req_i,
  output word_t    result_o,
  output logic     cmp_o
);

  // Operand aliases
  word_t op_a;
  word_t op_b;

  // Shared adder and subtractor results
  word_t sum;
  word_t diff;

  // Shift amount from the low bits of b
  logic [4:0] shamt;
  word_t      shl;
  word_t      shr_log;
  word_t      shr_ari;

  // Comparison terms
  logic is_equal;
  logic lt_signed;
  logic lt_unsigned;

  assign op_a = req_i.a;
  assign op_b = req_i.b;

  assign sum  = op_a + op_b;
  assign diff = op_a - op_b;

  //////////////////////////////////////////////////////////////////////
  // Shifter
  //////////////////////////////////////////////////////////////////////

  assign shamt   = op_b[4:0];
  assign shl     = op_a << shamt;
  assign shr_log = op_a >> shamt;
  // Arithmetic right shift keeps the sign bit
  assign shr_ari = word_t'($signed(op_a) >>> shamt);

  //////////////////////////////////////////////////////////////////////
  // Comparator
  //////////////////////////////////////////////////////////////////////

  assign is_equal    = (op_a == op_b);
  assign lt_unsigned = (op_a < op_b);
  assign lt_signed   = ($signed(op_a) < $signed(op_b));

  //////////////////////////////////////////////////////////////////////
  // Operation select
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    // Defaults for the non-compare group
    result_o = '0;
    cmp_o    = 1'b0;

    case (req_i.operator)
      ALU_ADD: result_o = sum;
      ALU_SUB: result_o = diff;
      ALU_AND: result_o = op_a & op_b;
      ALU_OR:  result_o = op_a | op_b;
      ALU_XOR: result_o = op_a ^ op_b;
      ALU_SLL: result_o = shl;
      ALU_SRL: result_o = shr_log;
      ALU_SRA: result_o = shr_ari;

      // Set-less-than, flag follows the result
      ALU_SLTS: cmp_o = lt_signed;
      ALU_SLTU: cmp_o = lt_unsigned;

      // Branch compares
      ALU_EQ:  cmp_o = is_equal;
      ALU_NE:  cmp_o = ~is_equal;
      ALU_LTS: cmp_o = lt_signed;
      ALU_LTU: cmp_o = lt_unsigned;
      ALU_GES: cmp_o = ~lt_signed;
      ALU_GEU: cmp_o = ~lt_unsigned;

      default:
      begin
        result_o = '0;
        cmp_o    = 1'b0;
      end
    endcase

    // Compare ops return the flag zero-extended
    if (req_i.operator >= ALU_SLTS)
    begin
      result_o = word_t'(cmp_o);
    end
  end

endmodule

`default_nettype wire

// File: ex_stage/ex_mult.sv
`timescale 1ns/100ps
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Multiply-accumulate unit
//////////////////////////////////////////////////////////////////////

module ex_mult
  import ex_pkg::*;
(
  input  mult_req_t req_i,
  input  word_t     op_a_i,
  input  word_t     op_b_i,
  input  word_t     mac_i,
  output word_t     result_o
);

  // Selected halfwords
  logic [15:0] half_a;
  logic [15:0] half_b;

  // Halfwords extended by one bit so signed and unsigned share one multiply
  logic signed [16:0] ext_a;
  logic signed [16:0] ext_b;

  // Halfword product, upper bits beyond 32 are dropped
  logic signed [33:0] half_prod;

  // Full-word product, low 32 bits only
  word_t full_prod;

  // Product before accumulate
  word_t prod;

  // Addend, zero when accumulate is off
  word_t addend;

  //////////////////////////////////////////////////////////////////////
  // Subword operand select
  //////////////////////////////////////////////////////////////////////

  // Upper or lower half of a
  assign half_a = req_i.sel_subword[0] ? op_a_i[31:16] : op_a_i[15:0];

  // Upper or lower half of b
  assign half_b = req_i.sel_subword[1] ? op_b_i[31:16] : op_b_i[15:0];

  // Sign bit only copied in when that operand is signed
  assign ext_a = {req_i.signed_mode[0] & half_a[15], half_a};
  assign ext_b = {req_i.signed_mode[1] & half_b[15], half_b};

  //////////////////////////////////////////////////////////////////////
  // Multipliers
  //////////////////////////////////////////////////////////////////////

  // 17x17 signed multiply covers all four signedness mixes
  assign half_prod = ext_a * ext_b;

  // Low word is the same for signed and unsigned full-word operands
  assign full_prod = op_a_i * op_b_i;

  // Mode select
  assign prod = req_i.vector_mode ? half_prod[31:0] : full_prod;

  //////////////////////////////////////////////////////////////////////
  // Accumulate
  //////////////////////////////////////////////////////////////////////

  assign addend = req_i.mac_en ? mac_i : '0;

  // Wraps modulo 2^32
  assign result_o = prod + addend;

endmodule

`default_nettype wire

// File: ex_stage/ex_stage.sv
`timescale 1ns/100ps
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Execute stage with ALU, MAC, result mux and EX/WB register
//////////////////////////////////////////////////////////////////////

module ex_stage
  import ex_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  // Operation requests from decode
  input  alu_req_t  alu_req_i,
  input  mult_req_t mult_req_i,

  // CSR read data
  input  logic      csr_access_i,
  input  word_t     csr_rdata_i,

  // Branch currently in EX
  input  logic      branch_in_ex_i,

  // ALU write port target
  input  logic      alu_we_i,
  input  reg_addr_t alu_waddr_i,

  // Load write-back target, passed on to WB
  input  logic      wb_we_i,
  input  reg_addr_t wb_waddr_i,

  // Readiness of the neighbouring stages
  input  logic      lsu_ready_ex_i,
  input  logic      wb_ready_i,

  // Forwarding and register file write
  output rf_wr_t    fw_o,

  // Branch outputs to fetch
  output word_t     jump_target_o,
  output logic      branch_decision_o,

  // EX/WB pipeline register
  output logic      wb_we_o,
  output reg_addr_t wb_waddr_o,

  // Stall control
  output logic      ex_ready_o,
  output logic      ex_valid_o
);

  word_t alu_result;
  logic  alu_cmp;
  word_t mult_result;
  word_t fw_wdata;

  //////////////////////////////////////////////////////////////////////
  // Functional units
  //////////////////////////////////////////////////////////////////////

  ex_alu i_ex_alu (
    .req_i    (alu_req_i),
    .result_o (alu_result),
    .cmp_o    (alu_cmp)
  );

  // Multiplier shares the ALU operands, c is the addend
  ex_mult i_ex_mult (
    .req_i    (mult_req_i),
    .op_a_i   (alu_req_i.a),
    .op_b_i   (alu_req_i.b),
    .mac_i    (alu_req_i.c),
    .result_o (mult_result)
  );

  //////////////////////////////////////////////////////////////////////
  // Result mux
  //////////////////////////////////////////////////////////////////////

  // CSR first, then multiplier, then ALU
  always_comb
  begin
    if (csr_access_i)
      fw_wdata = csr_rdata_i;
    else if (mult_req_i.en)
      fw_wdata = mult_result;
    else
      fw_wdata = alu_result;
  end

  // Write enable and address come straight from decode
  assign fw_o = '{we: alu_we_i, waddr: alu_waddr_i, wdata: fw_wdata};

  // Branch taken when the compare holds, target is operand c
  assign branch_decision_o = alu_cmp;
  assign jump_target_o     = alu_req_i.c;

  //////////////////////////////////////////////////////////////////////
  // Stall rule and EX/WB register
  //////////////////////////////////////////////////////////////////////

  // A branch in EX overrides LSU and WB back-pressure
  assign ex_ready_o = (lsu_ready_ex_i & wb_ready_i) | branch_in_ex_i;
  assign ex_valid_o = ex_ready_o;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wb_we_o    <= 1'b0;
      wb_waddr_o <= '0;
    end
    else if (ex_valid_o)
    begin
      // New instruction moves into WB
      wb_we_o    <= wb_we_i;
      wb_waddr_o <= wb_waddr_i;
    end
    else if (wb_ready_i)
    begin
      // Nothing new, flush the write, address kept
      wb_we_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: hdl/ex_regfile.sv
`timescale 1ns/100ps
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Integer register file with one write port and one read port
//////////////////////////////////////////////////////////////////////

module ex_regfile
  import ex_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  // Write port from the forwarding path
  input  rf_wr_t    wr_i,

  // Combinational read port
  input  reg_addr_t raddr_i,
  output word_t     rdata_o
);

  // Storage where entry zero is never written
  word_t regs [REG_COUNT];

  // Write qualified against register zero
  logic wr_en;

  assign wr_en = wr_i.we && (wr_i.waddr != '0);

  //////////////////////////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      // All registers come up at zero
      for (int i = 0; i < REG_COUNT; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (wr_en)
    begin
      regs[wr_i.waddr] <= wr_i.wdata;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////////////////////////

  // Entry zero keeps its reset value of zero
  assign rdata_o = regs[raddr_i];

endmodule

`default_nettype wire

// File: hdl/ex_top.sv
`timescale 1ns/100ps
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Execute stage plus register file
//////////////////////////////////////////////////////////////////////

module ex_top
  import ex_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  // Decode side
  input  alu_req_t  alu_req_i,
  input  mult_req_t mult_req_i,
  input  logic      csr_access_i,
  input  word_t     csr_rdata_i,
  input  logic      branch_in_ex_i,
  input  logic      alu_we_i,
  input  reg_addr_t alu_waddr_i,
  input  logic      wb_we_i,
  input  reg_addr_t wb_waddr_i,

  // Stall inputs
  input  logic      lsu_ready_ex_i,
  input  logic      wb_ready_i,

  // Register file observation port
  input  reg_addr_t rf_raddr_i,
  output word_t     rf_rdata_o,

  // Execute stage results
  output rf_wr_t    fw_o,
  output word_t     jump_target_o,
  output logic      branch_decision_o,
  output logic      wb_we_o,
  output reg_addr_t wb_waddr_o,
  output logic      ex_ready_o,
  output logic      ex_valid_o
);

  // Forwarding write from EX into the register file
  rf_wr_t fw;

  ex_stage i_ex_stage (
    .clk               (clk),
    .rst_n             (rst_n),
    .alu_req_i         (alu_req_i),
    .mult_req_i        (mult_req_i),
    .csr_access_i      (csr_access_i),
    .csr_rdata_i       (csr_rdata_i),
    .branch_in_ex_i    (branch_in_ex_i),
    .alu_we_i          (alu_we_i),
    .alu_waddr_i       (alu_waddr_i),
    .wb_we_i           (wb_we_i),
    .wb_waddr_i        (wb_waddr_i),
    .lsu_ready_ex_i    (lsu_ready_ex_i),
    .wb_ready_i        (wb_ready_i),
    .fw_o              (fw),
    .jump_target_o     (jump_target_o),
    .branch_decision_o (branch_decision_o),
    .wb_we_o           (wb_we_o),
    .wb_waddr_o        (wb_waddr_o),
    .ex_ready_o        (ex_ready_o),
    .ex_valid_o        (ex_valid_o)
  );

  ex_regfile i_ex_regfile (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_i    (fw),
    .raddr_i (rf_raddr_i),
    .rdata_o (rf_rdata_o)
  );

  // Same write also leaves the top level
  assign fw_o = fw;

endmodule

`default_nettype wire

// File: sim/ex_checker.sv
`timescale 1ns/100ps
`default_nettype none

module ex_checker
  import ex_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  // Stimulus as seen by the DUT
  input  alu_req_t  alu_req_i,
  input  logic      alu_we_i,
  input  reg_addr_t alu_waddr_i,
  input  logic      wb_we_i,
  input  reg_addr_t wb_waddr_i,
  input  logic      lsu_ready_ex_i,
  input  logic      wb_ready_i,
  input  logic      branch_in_ex_i,
  input  reg_addr_t rf_raddr_i,

  // Reference results from the testbench
  input  word_t     exp_wdata_i,
  input  logic      exp_branch_i,

  // DUT outputs under check
  input  rf_wr_t    dut_fw_i,
  input  word_t     dut_jump_target_i,
  input  logic      dut_branch_decision_i,
  input  logic      dut_wb_we_i,
  input  reg_addr_t dut_wb_waddr_i,
  input  logic      dut_ex_ready_i,
  input  logic      dut_ex_valid_i,
  input  word_t     dut_rf_rdata_i,

  output int        error_count_o
);

  // Register file model, entry zero stays zero
  word_t     model_regs [REG_COUNT];

  // Expected EX/WB register contents
  logic      exp_wb_we;
  reg_addr_t exp_wb_waddr;

  // Stall rule, a branch overrides back-pressure
  logic      exp_ready;

  int        errors = 0;

  assign error_count_o = errors;
  assign exp_ready     = (lsu_ready_ex_i && wb_ready_i) || branch_in_ex_i;

  task automatic compare_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
    if (exp_v !== act_v)
    begin
      errors++;
      $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp_v, act_v);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Models, advanced on the rising edge
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < REG_COUNT; i++)
      begin
        model_regs[i] <= '0;
      end
      exp_wb_we    <= 1'b0;
      exp_wb_waddr <= '0;
    end
    else
    begin
      // Writes to register zero are dropped
      if (alu_we_i && (alu_waddr_i != '0))
        model_regs[alu_waddr_i] <= exp_wdata_i;

      // Load, clear or hold
      if (exp_ready)
      begin
        exp_wb_we    <= wb_we_i;
        exp_wb_waddr <= wb_waddr_i;
      end
      else if (wb_ready_i)
        exp_wb_we <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Compare in mid cycle
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk)
  begin
    // WB register is also checked under reset
    compare_value("wb_we_o", 32'(exp_wb_we), 32'(dut_wb_we_i));
    compare_value("wb_waddr_o", 32'(exp_wb_waddr), 32'(dut_wb_waddr_i));
    if (rst_n)
    begin
      compare_value("fw_o.wdata", exp_wdata_i, dut_fw_i.wdata);
      compare_value("fw_o.we", 32'(alu_we_i), 32'(dut_fw_i.we));
      compare_value("fw_o.waddr", 32'(alu_waddr_i), 32'(dut_fw_i.waddr));
      compare_value("branch_decision_o", 32'(exp_branch_i), 32'(dut_branch_decision_i));
      compare_value("jump_target_o", alu_req_i.c, dut_jump_target_i);
      compare_value("ex_ready_o", 32'(exp_ready), 32'(dut_ex_ready_i));
      compare_value("ex_valid_o", 32'(exp_ready), 32'(dut_ex_valid_i));
      compare_value("rf_rdata_o", model_regs[rf_raddr_i], dut_rf_rdata_i);
    end
  end

endmodule

`default_nettype wire

// File: sim/ex_tb.sv
`timescale 1ns/100ps
`default_nettype none

module ex_tb
  import ex_pkg::*;
();

  localparam int CLK_PERIOD   = 40;
  localparam int DRIVE_DELAY  = 5;
  localparam int RESET_CYCLES = 4;

  // Vector counts per test group
  localparam int EDGE_N     = 6;
  localparam int ALU_RAND_N = 8;
  localparam int ALU_VEC    = 16 * (EDGE_N + ALU_RAND_N);
  // Full word 2x4, vector 4 sel x 4 sign x 2 mac x 2
  localparam int MULT_VEC   = 8 + 64;
  localparam int PRIO_VEC   = 16;
  localparam int RF_WRITE_N = 64;
  localparam int RF_VEC     = RF_WRITE_N + REG_COUNT;
  localparam int STALL_VEC  = 64;
  localparam int VEC_TOTAL  = ALU_VEC + MULT_VEC + PRIO_VEC + RF_VEC + STALL_VEC;
  localparam int WATCHDOG_NS = (RESET_CYCLES + VEC_TOTAL + 25) * CLK_PERIOD;

  // Edge operands, includes shift amounts 0 and 31
  localparam word_t EDGE_A [EDGE_N] = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000,
                                        32'h7fff_ffff, 32'h8000_0001, 32'hffff_fffe};
  localparam word_t EDGE_B [EDGE_N] = '{32'h0000_0000, 32'hffff_ffff, 32'h0000_0001,
                                        32'h8000_0000, 32'h0000_001f, 32'h0000_0000};

  typedef struct packed {
    word_t wdata;
    logic  branch;
  } ref_t;

  logic      clk;
  logic      rst_n;
  alu_req_t  alu_req;
  mult_req_t mult_req;
  logic      csr_access;
  word_t     csr_rdata;
  logic      branch_in_ex;
  logic      alu_we;
  reg_addr_t alu_waddr;
  logic      wb_we;
  reg_addr_t wb_waddr;
  logic      lsu_ready_ex;
  logic      wb_ready;
  reg_addr_t rf_raddr;

  word_t     rf_rdata;
  rf_wr_t    fw;
  word_t     jump_target;
  logic      branch_decision;
  logic      dut_wb_we;
  reg_addr_t dut_wb_waddr;
  logic      ex_ready;
  logic      ex_valid;

  ref_t      exp_res;
  int        error_count;
  integer    seed = 32'h39de_83cb;

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ex_top i_ex_top (
    .clk (clk), .rst_n (rst_n),
    .alu_req_i (alu_req), .mult_req_i (mult_req),
    .csr_access_i (csr_access), .csr_rdata_i (csr_rdata),
    .branch_in_ex_i (branch_in_ex),
    .alu_we_i (alu_we), .alu_waddr_i (alu_waddr),
    .wb_we_i (wb_we), .wb_waddr_i (wb_waddr),
    .lsu_ready_ex_i (lsu_ready_ex), .wb_ready_i (wb_ready),
    .rf_raddr_i (rf_raddr), .rf_rdata_o (rf_rdata),
    .fw_o (fw), .jump_target_o (jump_target), .branch_decision_o (branch_decision),
    .wb_we_o (dut_wb_we), .wb_waddr_o (dut_wb_waddr),
    .ex_ready_o (ex_ready), .ex_valid_o (ex_valid)
  );

  ex_checker i_ex_checker (
    .clk (clk), .rst_n (rst_n),
    .alu_req_i (alu_req), .alu_we_i (alu_we), .alu_waddr_i (alu_waddr),
    .wb_we_i (wb_we), .wb_waddr_i (wb_waddr),
    .lsu_ready_ex_i (lsu_ready_ex), .wb_ready_i (wb_ready),
    .branch_in_ex_i (branch_in_ex), .rf_raddr_i (rf_raddr),
    .exp_wdata_i (exp_res.wdata), .exp_branch_i (exp_res.branch),
    .dut_fw_i (fw), .dut_jump_target_i (jump_target),
    .dut_branch_decision_i (branch_decision),
    .dut_wb_we_i (dut_wb_we), .dut_wb_waddr_i (dut_wb_waddr),
    .dut_ex_ready_i (ex_ready), .dut_ex_valid_i (ex_valid),
    .dut_rf_rdata_i (rf_rdata), .error_count_o (error_count)
  );

  function automatic word_t rand_word();
    rand_word = $random(seed);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Reference model of the forwarded word and branch flag
  //////////////////////////////////////////////////////////////////////

  function automatic ref_t ex_ref(alu_req_t req, mult_req_t mreq, logic csr_acc, word_t csr_d);
    ref_t        r;
    word_t       alu_res;
    word_t       mul_res;
    logic        cmp;
    logic        lts;
    logic        ltu;
    logic [63:0] wide;
    logic [15:0] ha;
    logic [15:0] hb;
    logic [63:0] pa;
    logic [63:0] pb;
    logic [63:0] prod;
    lts     = $signed(req.a) < $signed(req.b);
    ltu     = req.a < req.b;
    cmp     = 1'b0;
    alu_res = '0;
    case (req.operator)
      ALU_ADD: alu_res = req.a + req.b;
      ALU_SUB: alu_res = req.a - req.b;
      ALU_AND: alu_res = req.a & req.b;
      ALU_OR:  alu_res = req.a | req.b;
      ALU_XOR: alu_res = req.a ^ req.b;
      ALU_SLL: alu_res = req.a << req.b[4:0];
      ALU_SRL: alu_res = req.a >> req.b[4:0];
      ALU_SRA:
      begin
        // Sign-extend to 64 bits, then a logical shift
        wide    = {{32{req.a[31]}}, req.a} >> req.b[4:0];
        alu_res = wide[31:0];
      end
      ALU_SLTS, ALU_LTS: cmp = lts;
      ALU_SLTU, ALU_LTU: cmp = ltu;
      ALU_EQ:  cmp = (req.a == req.b);
      ALU_NE:  cmp = (req.a != req.b);
      ALU_GES: cmp = !lts;
      ALU_GEU: cmp = !ltu;
      default: alu_res = '0;
    endcase
    if (req.operator >= ALU_SLTS)
      alu_res = {31'b0, cmp};
    // Multiplier operands widened to 64 bits
    ha = mreq.sel_subword[0] ? req.a[31:16] : req.a[15:0];
    hb = mreq.sel_subword[1] ? req.b[31:16] : req.b[15:0];
    if (mreq.vector_mode)
    begin
      pa = mreq.signed_mode[0] ? {{48{ha[15]}}, ha} : {48'b0, ha};
      pb = mreq.signed_mode[1] ? {{48{hb[15]}}, hb} : {48'b0, hb};
    end
    else
    begin
      pa = {32'b0, req.a};
      pb = {32'b0, req.b};
    end
    prod    = pa * pb;
    mul_res = prod[31:0] + (mreq.mac_en ? req.c : 32'b0);
    if (csr_acc)
      r.wdata = csr_d;
    else if (mreq.en)
      r.wdata = mul_res;
    else
      r.wdata = alu_res;
    r.branch = cmp;
    return r;
  endfunction

  always_comb exp_res = ex_ref(alu_req, mult_req, csr_access, csr_rdata);

  // Next drive point, shortly after the rising edge
  task automatic next_slot();
    @(posedge clk);
    #(DRIVE_DELAY);
  endtask

  // Watchdog
  initial
  begin
    #(WATCHDOG_NS);
    $display("Timeout: stimulus did not finish within %0d ns", WATCHDOG_NS);
    $display("=== FAIL ===");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    int op;
    int k;
    int s;
    int g;
    int m;
    rst_n        = 1'b0;
    alu_req      = '0;
    mult_req     = '0;
    csr_access   = 1'b0;
    csr_rdata    = '0;
    branch_in_ex = 1'b0;
    alu_we       = 1'b0;
    alu_waddr    = '0;
    wb_we        = 1'b0;
    wb_waddr     = '0;
    lsu_ready_ex = 1'b1;
    wb_ready     = 1'b1;
    rf_raddr     = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #(DRIVE_DELAY);
    rst_n = 1'b1;

    // All ALU ops, edge then random operands, c as jump target
    for (op = 0; op < 16; op++)
    begin
      for (k = 0; k < EDGE_N + ALU_RAND_N; k++)
      begin
        alu_req.operator = alu_op_e'(op);
        alu_req.a = (k < EDGE_N) ? EDGE_A[k] : rand_word();
        alu_req.b = (k < EDGE_N) ? EDGE_B[k] : rand_word();
        alu_req.c = rand_word();
        next_slot();
      end
    end

    // Multiplier in full-word mode, with and without accumulate
    alu_req.operator = ALU_ADD;
    mult_req.en      = 1'b1;
    for (m = 0; m < 2; m++)
    begin
      for (k = 0; k < 4; k++)
      begin
        mult_req.mac_en = 1'(m);
        alu_req.a = rand_word();
        alu_req.b = rand_word();
        alu_req.c = rand_word();
        next_slot();
      end
    end

    // Halfword mode over every subword and sign mix
    mult_req.vector_mode = 1'b1;
    for (s = 0; s < 4; s++)
      for (g = 0; g < 4; g++)
        for (m = 0; m < 2; m++)
          for (k = 0; k < 2; k++)
          begin
            mult_req.sel_subword = 2'(s);
            mult_req.signed_mode = 2'(g);
            mult_req.mac_en      = 1'(m);
            alu_req.a = rand_word();
            alu_req.b = rand_word();
            alu_req.c = rand_word();
            next_slot();
          end
    mult_req = '0;

    // Result priority between CSR, multiplier and ALU
    alu_req.operator = ALU_XOR;
    for (g = 0; g < 4; g++)
    begin
      for (k = 0; k < 4; k++)
      begin
        csr_access  = g[0];
        mult_req.en = g[1];
        csr_rdata   = rand_word();
        alu_req.a   = rand_word();
        alu_req.b   = rand_word();
        alu_req.c   = rand_word();
        next_slot();
      end
    end
    csr_access = 1'b0;
    mult_req   = '0;

    // Register file writes, the first two target register zero
    alu_req.operator = ALU_ADD;
    alu_we           = 1'b1;
    for (k = 0; k < RF_WRITE_N; k++)
    begin
      alu_waddr = (k < 2) ? '0 : reg_addr_t'(rand_word());
      rf_raddr  = reg_addr_t'(rand_word());
      alu_req.a = rand_word();
      alu_req.b = rand_word();
      next_slot();
    end
    // Read back every address
    alu_we = 1'b0;
    for (k = 0; k < REG_COUNT; k++)
    begin
      rf_raddr = reg_addr_t'(k);
      next_slot();
    end

    // Stall walk, ordered combinations first, then random
    for (k = 0; k < STALL_VEC; k++)
    begin
      {lsu_ready_ex, wb_ready, branch_in_ex} = (k < 32) ? 3'(k) : 3'(rand_word());
      wb_we    = 1'(rand_word());
      wb_waddr = reg_addr_t'(rand_word());
      next_slot();
    end
    lsu_ready_ex = 1'b1;
    wb_ready     = 1'b1;
    branch_in_ex = 1'b0;
    next_slot();

    $display("Errors: %0d", error_count);
    if (error_count == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
common/ex_pkg.sv
ex_stage/ex_alu.sv
ex_stage/ex_mult.sv
ex_stage/ex_stage.sv
hdl/ex_regfile.sv
hdl/ex_top.sv
sim/ex_checker.sv
sim/ex_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module ex_tb -f files.f -o ex_sim

sim_out=$(./obj_dir/ex_sim)
echo "$sim_out"

if echo "$sim_out" | grep -qxF "=== PASS ==="; then
  exit 0
fi
exit 1
